// File: dbg_comm_pkg.sv
// debug link bridge shared protocol codes, widths and byte-lane mapping
package dbg_comm_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------

    localparam int byte_w     = 8;
    localparam int word_w     = 32;
    localparam int data_bytes = word_w / byte_w;
    localparam int reg_adr_w  = 4;
    localparam int sel_w      = 4;

    // ------------------------------------------------------------------
    // host command opcodes
    // ------------------------------------------------------------------

    localparam logic [byte_w-1:0] cmd_nop       = 8'h00;
    localparam logic [byte_w-1:0] cmd_status    = 8'h01;
    localparam logic [byte_w-1:0] cmd_dbg_write = 8'h02;
    localparam logic [byte_w-1:0] cmd_dbg_read  = 8'h03;

    // set on top of the opcode to form the ack code
    localparam logic [byte_w-1:0] ack_flag = 8'h80;

    // ------------------------------------------------------------------
    // command kind
    // ------------------------------------------------------------------

    // encodings follow the low opcode bits so the ack code is kind | ack_flag
    typedef enum logic [1:0] {
        kind_nop    = 2'd0,
        kind_status = 2'd1,
        kind_write  = 2'd2,
        kind_read   = 2'd3
    } cmd_kind_t;

    // ------------------------------------------------------------------
    // byte ordering
    // ------------------------------------------------------------------

    // position 0 is the first byte on the link
    // endian high puts the first byte in the top lane
    function automatic logic [1:0] byte_lane(
        input logic [1:0] pos,
        input logic       endian
    );
        logic [1:0] lane;
        if (endian) begin
            lane = 2'd3 - pos;
        end else begin
            lane = pos;
        end
        return lane;
    endfunction

endpackage

// File: dbg_cmd_rx.sv
// debug command receiver: decodes host opcodes and gathers selector and data bytes
module dbg_cmd_rx (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  endian_i,
    input  logic [dbg_comm_pkg::byte_w-1:0]       rx_data_i,
    input  logic                                  rx_valid_i,
    input  logic                                  rsp_done_i,
    output logic                                  rx_ready_o,
    output logic                                  cmd_valid_o,
    output dbg_comm_pkg::cmd_kind_t               cmd_kind_o,
    output logic [dbg_comm_pkg::reg_adr_w-1:0]    cmd_adr_o,
    output logic [dbg_comm_pkg::sel_w-1:0]        cmd_sel_o,
    output logic [dbg_comm_pkg::word_w-1:0]       cmd_wdata_o
);

    typedef enum logic [1:0] {
        st_opcode,
        st_select,
        st_data,
        st_wait
    } state_t;

    state_t     state;
    logic [1:0] byte_cnt;
    logic [1:0] lane;
    logic       accept;

    // host is stalled while a command is in flight
    assign rx_ready_o = (state != st_wait);
    assign accept     = rx_valid_i && rx_ready_o;
    assign lane       = dbg_comm_pkg::byte_lane(byte_cnt, endian_i);

    // ------------------------------------------------------------------
    // control FSM
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= st_opcode;
            byte_cnt    <= 2'd0;
            cmd_valid_o <= 1'b0;
        end else begin
            cmd_valid_o <= 1'b0;
            case (state)
                st_opcode: begin
                    if (accept) begin
                        case (rx_data_i)
                            dbg_comm_pkg::cmd_nop,
                            dbg_comm_pkg::cmd_status: begin
                                cmd_valid_o <= 1'b1;
                                state       <= st_wait;
                            end
                            dbg_comm_pkg::cmd_dbg_write,
                            dbg_comm_pkg::cmd_dbg_read: begin
                                state <= st_select;
                            end
                            // unknown opcodes are dropped here
                            default: state <= st_opcode;
                        endcase
                    end
                end
                st_select: begin
                    byte_cnt <= 2'd0;
                    if (accept) begin
                        if (cmd_kind_o == dbg_comm_pkg::kind_read) begin
                            cmd_valid_o <= 1'b1;
                            state       <= st_wait;
                        end else begin
                            state <= st_data;
                        end
                    end
                end
                st_data: begin
                    if (accept) begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'(dbg_comm_pkg::data_bytes - 1)) begin
                            cmd_valid_o <= 1'b1;
                            state       <= st_wait;
                        end
                    end
                end
                default: begin
                    if (rsp_done_i) begin
                        state <= st_opcode;
                    end
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // command fields
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (accept && state == st_opcode) begin
            cmd_kind_o <= dbg_comm_pkg::cmd_kind_t'(rx_data_i[1:0]);
        end
        // selector byte: enables high, address low
        if (accept && state == st_select) begin
            cmd_adr_o <= rx_data_i[dbg_comm_pkg::reg_adr_w-1:0];
            cmd_sel_o <= rx_data_i[dbg_comm_pkg::byte_w-1:dbg_comm_pkg::reg_adr_w];
        end
        if (accept && state == st_data) begin
            cmd_wdata_o[lane*dbg_comm_pkg::byte_w +: dbg_comm_pkg::byte_w] <= rx_data_i;
        end
    end

endmodule

// File: dbg_bus_master.sv
// debug register bus master: one strobe/acknowledge transfer per command
module dbg_bus_master (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  cmd_valid_i,
    input  dbg_comm_pkg::cmd_kind_t               cmd_kind_i,
    input  logic [dbg_comm_pkg::reg_adr_w-1:0]    cmd_adr_i,
    input  logic [dbg_comm_pkg::sel_w-1:0]        cmd_sel_i,
    input  logic [dbg_comm_pkg::word_w-1:0]       cmd_wdata_i,
    input  logic [dbg_comm_pkg::word_w-1:0]       dbg_dat_i,
    input  logic                                  dbg_ack_i,
    output logic [dbg_comm_pkg::reg_adr_w-1:0]    dbg_adr_o,
    output logic [dbg_comm_pkg::word_w-1:0]       dbg_dat_o,
    output logic                                  dbg_we_o,
    output logic [dbg_comm_pkg::sel_w-1:0]        dbg_sel_o,
    output logic                                  dbg_stb_o,
    output logic                                  rsp_valid_o,
    output dbg_comm_pkg::cmd_kind_t               rsp_kind_o,
    output logic [dbg_comm_pkg::word_w-1:0]       rsp_rdata_o
);

    logic needs_bus;
    logic bus_done;

    assign needs_bus = (cmd_kind_i == dbg_comm_pkg::kind_write) ||
                       (cmd_kind_i == dbg_comm_pkg::kind_read);
    assign bus_done  = dbg_stb_o && dbg_ack_i;

    // ------------------------------------------------------------------
    // strobe and response pulse
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            dbg_stb_o   <= 1'b0;
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= 1'b0;
            if (cmd_valid_i) begin
                // nop and status answer straight away
                dbg_stb_o   <= needs_bus;
                rsp_valid_o <= !needs_bus;
            end else if (bus_done) begin
                dbg_stb_o   <= 1'b0;
                rsp_valid_o <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // transfer fields, steady for the whole strobe
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (cmd_valid_i) begin
            dbg_adr_o  <= cmd_adr_i;
            dbg_dat_o  <= cmd_wdata_i;
            dbg_sel_o  <= cmd_sel_i;
            dbg_we_o   <= (cmd_kind_i == dbg_comm_pkg::kind_write);
            rsp_kind_o <= cmd_kind_i;
        end
        // slave data is valid in the ack cycle only
        if (bus_done) begin
            rsp_rdata_o <= dbg_dat_i;
        end
    end

endmodule

// File: dbg_rsp_tx.sv
// response transmitter: ack code, then the status byte or the read data bytes
module dbg_rsp_tx (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  endian_i,
    input  logic                                  rsp_valid_i,
    input  dbg_comm_pkg::cmd_kind_t               rsp_kind_i,
    input  logic [dbg_comm_pkg::word_w-1:0]       rsp_rdata_i,
    input  logic                                  tx_ready_i,
    output logic [dbg_comm_pkg::byte_w-1:0]       tx_data_o,
    output logic                                  tx_valid_o,
    output logic                                  rsp_done_o
);

    typedef enum logic [1:0] {
        st_idle,
        st_ack,
        st_status,
        st_data
    } state_t;

    state_t                           state;
    dbg_comm_pkg::cmd_kind_t          kind_q;
    logic [dbg_comm_pkg::word_w-1:0]  rdata_q;
    logic [1:0]                       byte_cnt;
    logic [1:0]                       lane;
    logic                             accept;

    assign tx_valid_o = (state != st_idle);
    assign accept     = tx_valid_o && tx_ready_i;
    assign lane       = dbg_comm_pkg::byte_lane(byte_cnt, endian_i);

    // byte on the link, a pure function of the state
    always_comb begin
        case (state)
            st_status: tx_data_o = {{(dbg_comm_pkg::byte_w-1){1'b0}}, endian_i};
            st_data:   tx_data_o = rdata_q[lane*dbg_comm_pkg::byte_w +: dbg_comm_pkg::byte_w];
            default:   tx_data_o = dbg_comm_pkg::ack_flag |
                                   {{(dbg_comm_pkg::byte_w-2){1'b0}}, kind_q};
        endcase
    end

    // ------------------------------------------------------------------
    // sequencer
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            byte_cnt   <= 2'd0;
            rsp_done_o <= 1'b0;
        end else begin
            rsp_done_o <= 1'b0;
            case (state)
                st_idle: begin
                    byte_cnt <= 2'd0;
                    if (rsp_valid_i) begin
                        state <= st_ack;
                    end
                end
                st_ack: begin
                    if (accept) begin
                        case (kind_q)
                            dbg_comm_pkg::kind_status: state <= st_status;
                            dbg_comm_pkg::kind_read:   state <= st_data;
                            default: begin
                                state      <= st_idle;
                                rsp_done_o <= 1'b1;
                            end
                        endcase
                    end
                end
                st_status: begin
                    if (accept) begin
                        state      <= st_idle;
                        rsp_done_o <= 1'b1;
                    end
                end
                default: begin
                    if (accept) begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'(dbg_comm_pkg::data_bytes - 1)) begin
                            state      <= st_idle;
                            rsp_done_o <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // response payload, held while the bytes go out
    always_ff @(posedge clk) begin
        if (rsp_valid_i && state == st_idle) begin
            kind_q  <= rsp_kind_i;
            rdata_q <= rsp_rdata_i;
        end
    end

endmodule

// File: dbg_comm_top.sv
// debug link bridge top: host byte stream to debug register port
module dbg_comm_top (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  endian_i,
    input  logic [dbg_comm_pkg::byte_w-1:0]       rx_data_i,
    input  logic                                  rx_valid_i,
    output logic                                  rx_ready_o,
    output logic [dbg_comm_pkg::byte_w-1:0]       tx_data_o,
    output logic                                  tx_valid_o,
    input  logic                                  tx_ready_i,
    output logic [dbg_comm_pkg::reg_adr_w-1:0]    dbg_adr_o,
    output logic [dbg_comm_pkg::word_w-1:0]       dbg_dat_o,
    output logic                                  dbg_we_o,
    output logic [dbg_comm_pkg::sel_w-1:0]        dbg_sel_o,
    output logic                                  dbg_stb_o,
    input  logic [dbg_comm_pkg::word_w-1:0]       dbg_dat_i,
    input  logic                                  dbg_ack_i
);

    // receiver to bus master
    logic                                cmd_valid;
    dbg_comm_pkg::cmd_kind_t             cmd_kind;
    logic [dbg_comm_pkg::reg_adr_w-1:0]  cmd_adr;
    logic [dbg_comm_pkg::sel_w-1:0]      cmd_sel;
    logic [dbg_comm_pkg::word_w-1:0]     cmd_wdata;

    // bus master to transmitter
    logic                                rsp_valid;
    dbg_comm_pkg::cmd_kind_t             rsp_kind;
    logic [dbg_comm_pkg::word_w-1:0]     rsp_rdata;

    // transmitter back to receiver
    logic                                rsp_done;

    dbg_cmd_rx u_cmd_rx (
        .clk         (clk),
        .reset       (reset),
        .endian_i    (endian_i),
        .rx_data_i   (rx_data_i),
        .rx_valid_i  (rx_valid_i),
        .rsp_done_i  (rsp_done),
        .rx_ready_o  (rx_ready_o),
        .cmd_valid_o (cmd_valid),
        .cmd_kind_o  (cmd_kind),
        .cmd_adr_o   (cmd_adr),
        .cmd_sel_o   (cmd_sel),
        .cmd_wdata_o (cmd_wdata)
    );

    dbg_bus_master u_bus_master (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid_i (cmd_valid),
        .cmd_kind_i  (cmd_kind),
        .cmd_adr_i   (cmd_adr),
        .cmd_sel_i   (cmd_sel),
        .cmd_wdata_i (cmd_wdata),
        .dbg_dat_i   (dbg_dat_i),
        .dbg_ack_i   (dbg_ack_i),
        .dbg_adr_o   (dbg_adr_o),
        .dbg_dat_o   (dbg_dat_o),
        .dbg_we_o    (dbg_we_o),
        .dbg_sel_o   (dbg_sel_o),
        .dbg_stb_o   (dbg_stb_o),
        .rsp_valid_o (rsp_valid),
        .rsp_kind_o  (rsp_kind),
        .rsp_rdata_o (rsp_rdata)
    );

    dbg_rsp_tx u_rsp_tx (
        .clk         (clk),
        .reset       (reset),
        .endian_i    (endian_i),
        .rsp_valid_i (rsp_valid),
        .rsp_kind_i  (rsp_kind),
        .rsp_rdata_i (rsp_rdata),
        .tx_ready_i  (tx_ready_i),
        .tx_data_o   (tx_data_o),
        .tx_valid_o  (tx_valid_o),
        .rsp_done_o  (rsp_done)
    );

endmodule

// File: tb_dbg_comm_tasks.svh
// host-side byte transfer and command tasks for the debug bridge testbench

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            value_errs++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // called and returns on a falling edge
    task automatic send_byte(input logic [7:0] b);
        repeat ($urandom_range(2, 0)) @(negedge clk);
        rx_data_i  = b;
        rx_valid_i = 1'b1;
        // ready only moves on a rising edge, so its level here holds for the next one
        while (!rx_ready_o) begin
            @(negedge clk);
        end
        @(negedge clk);
        rx_valid_i = 1'b0;
    endtask

    task automatic recv_byte(input logic [7:0] exp, input string name);
        logic [7:0] got;
        logic       taken;
        taken = 1'b0;
        got   = '0;
        while (!taken) begin
            // stall roughly one cycle in three
            tx_ready_i = ($urandom_range(2, 0) != 0);
            taken      = tx_valid_o && tx_ready_i;
            got        = tx_data_o;
            @(negedge clk);
        end
        tx_ready_i = 1'b0;
        check_value(name, 32'(exp), 32'(got));
    endtask

    task automatic end_response();
        awaiting_rsp = 1'b0;
        while (!rx_ready_o) begin
            @(negedge clk);
        end
        // nothing more may follow a complete response
        check_value("tx_valid_o", 0, 32'(tx_valid_o));
    endtask

    task automatic issue_nop();
        send_byte(dbg_comm_pkg::cmd_nop);
        awaiting_rsp = 1'b1;
        recv_byte(dbg_comm_pkg::ack_flag | dbg_comm_pkg::cmd_nop, "tx_data_o");
        end_response();
    endtask

    task automatic query_status();
        send_byte(dbg_comm_pkg::cmd_status);
        awaiting_rsp = 1'b1;
        recv_byte(dbg_comm_pkg::ack_flag | dbg_comm_pkg::cmd_status, "tx_data_o");
        recv_byte({7'd0, endian_i}, "tx_data_o");
        end_response();
    endtask

    task automatic write_reg(input logic [3:0] adr, input logic [3:0] sel,
                             input logic [31:0] data);
        int lane;
        send_byte(dbg_comm_pkg::cmd_dbg_write);
        send_byte({sel, adr});
        for (int p = 0; p < 4; p++) begin
            // first link byte lands in lane 0 or in lane 3 with endian high
            lane = endian_i ? 3 - p : p;
            send_byte(data[8*p +: 8]);
            if (sel[lane]) begin
                exp_regs[adr][8*lane +: 8] = data[8*p +: 8];
            end
        end
        awaiting_rsp = 1'b1;
        recv_byte(dbg_comm_pkg::ack_flag | dbg_comm_pkg::cmd_dbg_write, "tx_data_o");
        end_response();
        check_value($sformatf("regs[%0d]", adr), exp_regs[adr], regs[adr]);
    endtask

    task automatic read_reg(input logic [3:0] adr);
        int lane;
        send_byte(dbg_comm_pkg::cmd_dbg_read);
        // enables are ignored on reads
        send_byte({4'($urandom_range(15, 0)), adr});
        awaiting_rsp = 1'b1;
        recv_byte(dbg_comm_pkg::ack_flag | dbg_comm_pkg::cmd_dbg_read, "tx_data_o");
        for (int p = 0; p < 4; p++) begin
            lane = endian_i ? 3 - p : p;
            recv_byte(exp_regs[adr][8*lane +: 8], "tx_data_o");
        end
        end_response();
    endtask

    task automatic drop_unknown(input logic [7:0] op);
        send_byte(op);
        repeat (8) begin
            assert (!tx_valid_o && !dbg_stb_o && rx_ready_o) else begin
                protocol_errs++;
                $display("unknown opcode %h got a response or stalled the link at %0t",
                         op, $time);
            end
            @(negedge clk);
        end
    endtask

// File: tb_dbg_comm.sv
// debug link bridge testbench with host model, register slave model and protocol checks
module tb_dbg_comm;

    localparam int clk_period = 4;
    localparam int n_loop     = 8;
    // one nop, then per endian a status, the writes, the reads, an unknown opcode and a read
    localparam int n_cmds     = 1 + 2 * (3 + 2 * n_loop);
    // generous bound on cycles for six command bytes, a bus cycle and five response bytes
    localparam int cmd_cycles = 64;

    logic                                  clk = 1'b0;
    logic                                  reset;
    logic                                  endian_i;
    logic [dbg_comm_pkg::byte_w-1:0]       rx_data_i;
    logic                                  rx_valid_i;
    logic                                  rx_ready_o;
    logic [dbg_comm_pkg::byte_w-1:0]       tx_data_o;
    logic                                  tx_valid_o;
    logic                                  tx_ready_i;
    logic [dbg_comm_pkg::reg_adr_w-1:0]    dbg_adr_o;
    logic [dbg_comm_pkg::word_w-1:0]       dbg_dat_o;
    logic                                  dbg_we_o;
    logic [dbg_comm_pkg::sel_w-1:0]        dbg_sel_o;
    logic                                  dbg_stb_o;
    logic [dbg_comm_pkg::word_w-1:0]       dbg_dat_i;
    logic                                  dbg_ack_i;

    logic [31:0] regs [16];
    logic [31:0] exp_regs [16];
    logic        awaiting_rsp;
    int          value_errs = 0;
    int          protocol_errs = 0;

    always #(clk_period / 2) clk = ~clk;

    dbg_comm_top dut (.*);

    // start contents differ for every address
    function automatic logic [31:0] fill_word(input int unsigned adr);
        return 32'h9e37_79b9 * (adr + 1);
    endfunction

    `include "tb_dbg_comm_tasks.svh"

    // ------------------------------------------------------------------
    // register slave model
    // ------------------------------------------------------------------

    initial begin
        int unsigned wait_left;
        logic        started;
        dbg_ack_i = 1'b0;
        dbg_dat_i = '0;
        started   = 1'b0;
        wait_left = 0;
        for (int i = 0; i < 16; i++) begin
            regs[i] = fill_word(i);
        end
        forever begin
            @(negedge clk);
            if (dbg_ack_i) begin
                // transfer completed on the last rising edge
                dbg_ack_i = 1'b0;
                started   = 1'b0;
            end else if (dbg_stb_o) begin
                if (!started) begin
                    started   = 1'b1;
                    wait_left = $urandom_range(3, 0);
                end
                if (wait_left == 0) begin
                    dbg_ack_i = 1'b1;
                    if (dbg_we_o) begin
                        for (int b = 0; b < 4; b++) begin
                            if (dbg_sel_o[b]) begin
                                regs[dbg_adr_o][8*b +: 8] = dbg_dat_o[8*b +: 8];
                            end
                        end
                    end else begin
                        dbg_dat_i = regs[dbg_adr_o];
                    end
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // protocol checks
    // ------------------------------------------------------------------

    // fields hold and the strobe stays up until the acknowledge
    assert property (@(posedge clk) disable iff (reset)
        dbg_stb_o && !dbg_ack_i |=> dbg_stb_o && $stable(dbg_adr_o) && $stable(dbg_dat_o)
            && $stable(dbg_we_o) && $stable(dbg_sel_o))
    else begin
        protocol_errs++;
        $display("register port changed or lost its strobe before the acknowledge at %0t",
                 $time);
    end

    assert property (@(posedge clk) disable iff (reset)
        tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_data_o))
    else begin
        protocol_errs++;
        $display("response byte changed or was withdrawn before it was taken at %0t", $time);
    end

    // host stays stalled from the last command byte to the last response byte
    assert property (@(posedge clk) disable iff (reset) awaiting_rsp |-> !rx_ready_o)
    else begin
        protocol_errs++;
        $display("rx_ready_o rose while a command was still in flight at %0t", $time);
    end

    // ------------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------------

    initial begin
        #((n_cmds * cmd_cycles * 2 + 8) * clk_period);
        $display("timeout: the command sequence did not complete in time");
        $display("tests failed");
        $finish;
    end

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------

    initial begin
        logic [7:0] op;
        void'($urandom(74));
        reset        = 1'b1;
        endian_i     = 1'b0;
        rx_data_i    = '0;
        rx_valid_i   = 1'b0;
        tx_ready_i   = 1'b0;
        awaiting_rsp = 1'b0;
        for (int i = 0; i < 16; i++) begin
            exp_regs[i] = fill_word(i);
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;

        check_value("rx_ready_o", 1, 32'(rx_ready_o));
        check_value("tx_valid_o", 0, 32'(tx_valid_o));
        check_value("dbg_stb_o", 0, 32'(dbg_stb_o));
        issue_nop();

        for (int e = 0; e < 2; e++) begin
            endian_i = e[0];
            query_status();
            repeat (n_loop) begin
                write_reg(4'($urandom_range(15, 0)), 4'($urandom_range(15, 0)), $urandom);
            end
            repeat (n_loop) begin
                read_reg(4'($urandom_range(15, 0)));
            end
            op = 8'($urandom_range(255, 4));
            drop_unknown(op);
            read_reg(4'($urandom_range(15, 0)));
        end

        repeat (4) @(negedge clk);
        $display("summary: %0d value errors, %0d protocol errors", value_errs, protocol_errs);
        if (value_errs == 0 && protocol_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+.
dbg_comm_pkg.sv
dbg_cmd_rx.sv
dbg_bus_master.sv
dbg_rsp_tx.sv
dbg_comm_top.sv
tb_dbg_comm.sv

// File: Makefile
# Verilator build and run for the debug link bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_dbg_comm
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= all tests passed

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard *.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass message shows up on a line of its own
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
